// ==== project.f ====
rtl/bp_pkg.sv
rtl/bp_pc_gen.sv
rtl/bp_btb.sv
rtl/bp_target_select.sv
rtl/bp_frontend_top.sv
tests/bp_frontend_assert.sv
tests/tb_bp_frontend.sv

// ==== Makefile ====
# Verilator build and run for the branch prediction frontend

VERILATOR ?= verilator
TOP       ?= tb_bp_frontend
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_bp_frontend.sv ====
// Testbench for the branch prediction frontend, driving fetch scenarios into bound checks
`timescale 1ns/1ns

module tb_bp_frontend
  import bp_pkg::*;
();

  logic            clk = 1'b0;
  logic            rst_n;
  logic [VLEN-1:0] boot_pc;
  logic            redirect;
  logic [VLEN-1:0] redirect_pc;
  btb_update_t     btb_update;
  logic            flush;
  logic            debug_mode;
  fetch_block_t    fetch;

  int timeouts   = 0;
  int mark       = 0;
  int tests_ok   = 0;
  int tests_bad  = 0;

  // 8 ns period
  always #4 clk = ~clk;

  bp_frontend_top #(
    .NR_ENTRIES (8)
  ) dut0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .boot_pc_i     (boot_pc),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .btb_update_i  (btb_update),
    .flush_i       (flush),
    .debug_mode_i  (debug_mode),
    .fetch_o       (fetch)
  );

  bind bp_frontend_top bp_frontend_assert #(
    .NR_ENTRIES (NR_ENTRIES)
  ) u_frontend_assert (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .boot_pc_i     (boot_pc_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .btb_update_i  (btb_update_i),
    .flush_i       (flush_i),
    .debug_mode_i  (debug_mode_i),
    .fetch_i       (fetch_o)
  );

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  function automatic int total_failures();
    return dut0.u_frontend_assert.fail_count + timeouts;
  endfunction

  // One-cycle update strobe, optionally in debug mode or alongside a flush
  task automatic apply_update(input logic [VLEN-1:0] pc, input logic [VLEN-1:0] tgt,
                              input logic dbg, input logic with_flush);
    @(posedge clk);
    btb_update <= '{valid: 1'b1, pc: pc, target_address: tgt};
    debug_mode <= dbg;
    flush      <= with_flush;
    @(posedge clk);
    btb_update.valid <= 1'b0;
    debug_mode       <= 1'b0;
    flush            <= 1'b0;
  endtask

  task automatic flush_buffer();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  task automatic redirect_fetch(input logic [VLEN-1:0] pc);
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= pc;
    @(posedge clk);
    redirect <= 1'b0;
  endtask

  // Sample at the falling edge, away from register updates
  task automatic await_record(input logic [VLEN-1:0] pc, input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(fetch.valid && fetch.pc == pc) && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!(fetch.valid && fetch.pc == pc)) begin
      $display("Timed out after %0d cycles waiting for a fetch record at pc %h", limit, pc);
      timeouts++;
    end
  endtask

  task automatic end_test(input string name);
    int failures;
    failures = total_failures() - mark;
    mark     = total_failures();
    if (failures != 0) begin
      $display("Fail at %0t ns: test %s saw %0d failed checks", $time, name, failures);
      tests_bad++;
    end else begin
      $display("Test %s finished with no failed checks", name);
      tests_ok++;
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    logic [VLEN-1:0] pc_a;
    logic [VLEN-1:0] pc_b;
    logic [VLEN-1:0] tgt_a;
    logic [VLEN-1:0] tgt_b;
    void'($urandom(67));
    // Boot mid-block to exercise the align-down step
    rst_n       = 1'b0;
    boot_pc     = 32'h0000_1002;
    redirect    = 1'b0;
    redirect_pc = '0;
    btb_update  = '0;
    flush       = 1'b0;
    debug_mode  = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Empty buffer, plain sequential stream
    await_record(32'h0000_1002, 10);
    await_record(32'h0000_1028, 20);
    end_test("sequential");

    flush_buffer();
    pc_a  = $urandom & 32'hffff_fffe;
    tgt_a = $urandom & 32'hffff_fffe;
    apply_update(pc_a, tgt_a, 1'b0, 1'b0);
    redirect_fetch(pc_a & 32'hffff_fffc);
    await_record(pc_a & 32'hffff_fffc, 10);
    await_record(tgt_a, 4);
    end_test("single_install");

    // Both slots filled, entry at slot 1 skips slot 0
    flush_buffer();
    pc_a  = $urandom & 32'hffff_fffc;
    tgt_a = $urandom & 32'hffff_fffe;
    tgt_b = $urandom & 32'hffff_fffe;
    apply_update(pc_a, tgt_a, 1'b0, 1'b0);
    apply_update(pc_a | 32'h2, tgt_b, 1'b0, 1'b0);
    redirect_fetch(pc_a | 32'h2);
    await_record(pc_a | 32'h2, 10);
    await_record(tgt_b, 4);
    end_test("start_slot");

    flush_buffer();
    pc_a = $urandom & 32'hffff_fffe;
    apply_update(pc_a, $urandom & 32'hffff_fffe, 1'b1, 1'b0);
    redirect_fetch(pc_a & 32'hffff_fffc);
    await_record(pc_a & 32'hffff_fffc, 10);
    await_record((pc_a & 32'hffff_fffc) + 32'd4, 4);
    end_test("debug_blocks_update");

    // Flush after install, then flush racing an update
    flush_buffer();
    pc_a = $urandom & 32'hffff_fffe;
    apply_update(pc_a, $urandom & 32'hffff_fffe, 1'b0, 1'b0);
    flush_buffer();
    redirect_fetch(pc_a & 32'hffff_fffc);
    await_record(pc_a & 32'hffff_fffc, 10);
    await_record((pc_a & 32'hffff_fffc) + 32'd4, 4);
    pc_b = $urandom & 32'hffff_fffe;
    apply_update(pc_b, $urandom & 32'hffff_fffe, 1'b0, 1'b1);
    redirect_fetch(pc_b & 32'hffff_fffc);
    await_record(pc_b & 32'hffff_fffc, 10);
    await_record((pc_b & 32'hffff_fffc) + 32'd4, 4);
    end_test("flush");

    // Same row and slot, different upper bits
    flush_buffer();
    pc_a  = $urandom & 32'hffff_fffe;
    pc_b  = pc_a ^ 32'h0001_0000;
    tgt_a = $urandom & 32'hffff_fffe;
    tgt_b = $urandom & 32'hffff_fffe;
    apply_update(pc_a, tgt_a, 1'b0, 1'b0);
    apply_update(pc_b, tgt_b, 1'b0, 1'b0);
    redirect_fetch(pc_a);
    await_record(pc_a, 10);
    await_record(tgt_b, 4);
    redirect_fetch(pc_b);
    await_record(pc_b, 10);
    await_record(tgt_b, 4);
    end_test("aliasing");

    $display("Summary: %0d tests clean, %0d tests with failures", tests_ok, tests_bad);
    if (tests_bad == 0 && total_failures() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/bp_frontend_assert.sv ====
// Bound checker modelling the target buffer and fetch PC stream to check every fetch record
`timescale 1ns/1ns

module bp_frontend_assert
  import bp_pkg::*;
#(
  parameter int unsigned NR_ENTRIES = 8
) (
  input logic            clk_i,
  input logic            rst_ni,
  input logic [VLEN-1:0] boot_pc_i,
  input logic            redirect_i,
  input logic [VLEN-1:0] redirect_pc_i,
  input btb_update_t     btb_update_i,
  input logic            flush_i,
  input logic            debug_mode_i,
  input fetch_block_t    fetch_i
);

  localparam int unsigned NR_ROWS  = NR_ENTRIES / INSTR_PER_FETCH;
  localparam int unsigned ROW_BITS = $clog2(NR_ROWS);

  // Read by the testbench
  int fail_count = 0;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Installed targets per row and slot
  logic [INSTR_PER_FETCH-1:0] tbl_valid [NR_ROWS];
  logic [VLEN-1:0]            tbl_target [NR_ROWS][INSTR_PER_FETCH];

  // Model fetch PC and the record expected on fetch_i
  logic [VLEN-1:0] model_pc_q;
  fetch_block_t    exp_q;

  logic                 hit;
  logic [SLOT_BITS-1:0] hit_slot;
  logic [VLEN-1:0]      hit_target;
  logic [ROW_BITS-1:0]  cur_row;
  logic [ROW_BITS-1:0]  upd_row;
  logic                 upd_slot;

  assign cur_row  = model_pc_q[2 +: ROW_BITS];
  assign upd_row  = btb_update_i.pc[2 +: ROW_BITS];
  assign upd_slot = btb_update_i.pc[1];

  // Scan from the top slot down, so the lowest eligible slot is left standing
  always_comb begin
    hit        = 1'b0;
    hit_slot   = '0;
    hit_target = '0;
    for (int s = INSTR_PER_FETCH - 1; s >= 0; s--) begin
      if (s >= int'(model_pc_q[1]) && tbl_valid[cur_row][s]) begin
        hit        = 1'b1;
        hit_slot   = SLOT_BITS'(s);
        hit_target = tbl_target[cur_row][s];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      model_pc_q <= boot_pc_i;
      exp_q      <= '0;
      for (int r = 0; r < NR_ROWS; r++) begin
        tbl_valid[r] <= '0;
      end
    end else begin
      exp_q <= '{valid: 1'b1, pc: model_pc_q, taken: hit, slot: hit_slot, target: hit_target};
      if (redirect_i) begin
        model_pc_q <= redirect_pc_i;
      end else if (hit) begin
        model_pc_q <= hit_target;
      end else begin
        model_pc_q <= (model_pc_q & 32'hffff_fffc) + 32'd4;
      end
      // Flush beats a same-cycle update
      if (flush_i) begin
        for (int r = 0; r < NR_ROWS; r++) begin
          tbl_valid[r] <= '0;
        end
      end else if (btb_update_i.valid && !debug_mode_i) begin
        tbl_valid[upd_row][upd_slot]  <= 1'b1;
        tbl_target[upd_row][upd_slot] <= btb_update_i.target_address;
      end
    end
  end

  // ----------------------------------------
  // Checks on the fetch stream
  // ----------------------------------------

  a_reset_invalid: assert property (@(posedge clk_i) !rst_ni |-> !fetch_i.valid)
    else begin
      $error("fetch record valid during reset");
      fail_count++;
    end

  a_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_i.valid == exp_q.valid)
    else begin
      $error("fetch record valid bit differs from model");
      fail_count++;
    end

  a_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_i.valid |-> fetch_i.pc == exp_q.pc)
    else begin
      $error("fetch record pc %h, model expects %h", fetch_i.pc, exp_q.pc);
      fail_count++;
    end

  a_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_i.valid |-> fetch_i.taken == exp_q.taken)
    else begin
      $error("taken flag wrong for pc %h", fetch_i.pc);
      fail_count++;
    end

  // Slot and target only matter on a taken block
  a_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_i.valid && fetch_i.taken |->
      fetch_i.slot == exp_q.slot && fetch_i.target == exp_q.target)
    else begin
      $error("slot or target wrong for pc %h", fetch_i.pc);
      fail_count++;
    end

endmodule

// ==== rtl/bp_frontend_top.sv ====
// Branch prediction frontend top chaining fetch PC stage, target buffer and target select
`timescale 1ns/1ns

module bp_frontend_top
  import bp_pkg::*;
#(
  // Buffer entry count
  parameter int unsigned NR_ENTRIES = 8
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [VLEN-1:0] boot_pc_i,
  // Execute redirect
  input  logic            redirect_i,
  input  logic [VLEN-1:0] redirect_pc_i,
  // Buffer training and invalidation
  input  btb_update_t     btb_update_i,
  input  logic            flush_i,
  input  logic            debug_mode_i,
  // Fetch block stream
  output fetch_block_t    fetch_o
);

  // Fetch PC to buffer and select
  logic [VLEN-1:0] fetch_pc;

  // Row read for the fetch PC
  btb_prediction_t [INSTR_PER_FETCH-1:0] btb_prediction;

  // Feedback to the PC stage
  logic            pred_taken;
  logic [VLEN-1:0] pred_target;

  bp_pc_gen i_pc_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .boot_pc_i     (boot_pc_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pred_taken_i  (pred_taken),
    .pred_target_i (pred_target),
    .fetch_pc_o    (fetch_pc)
  );

  bp_btb #(
    .NR_ENTRIES (NR_ENTRIES)
  ) i_btb (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .debug_mode_i     (debug_mode_i),
    .vpc_i            (fetch_pc),
    .btb_update_i     (btb_update_i),
    .btb_prediction_o (btb_prediction)
  );

  bp_target_select i_target_select (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fetch_pc_i       (fetch_pc),
    .btb_prediction_i (btb_prediction),
    .pred_taken_o     (pred_taken),
    .pred_target_o    (pred_target),
    .fetch_o          (fetch_o)
  );

endmodule

// ==== rtl/bp_target_select.sv ====
// Target select stage scanning the block slots and registering the fetch block record
`timescale 1ns/1ns

module bp_target_select
  import bp_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Current fetch PC
  input  logic [VLEN-1:0]                       fetch_pc_i,
  // Buffer row for that PC
  input  btb_prediction_t [INSTR_PER_FETCH-1:0] btb_prediction_i,
  // Taken decision back to the PC stage
  output logic                                  pred_taken_o,
  output logic [VLEN-1:0]                       pred_target_o,
  // Record for the previous fetch PC
  output fetch_block_t                          fetch_o
);

  // Slot the fetch PC enters the block at
  logic [SLOT_BITS-1:0] start_slot;

  // Scan result
  logic                 hit;
  logic [SLOT_BITS-1:0] hit_slot;
  logic [VLEN-1:0]      hit_target;

  // Registered record
  fetch_block_t fetch_q;

  assign start_slot = fetch_pc_i[FETCH_OFFSET-1 -: SLOT_BITS];

  // First valid slot at or above the entry slot wins
  // Slots below the entry point were already passed
  always_comb begin
    hit        = 1'b0;
    hit_slot   = '0;
    hit_target = '0;
    for (int unsigned s = 0; s < INSTR_PER_FETCH; s++) begin
      if (!hit && (s >= start_slot) && btb_prediction_i[s].valid) begin
        hit        = 1'b1;
        hit_slot   = SLOT_BITS'(s);
        hit_target = btb_prediction_i[s].target_address;
      end
    end
  end

  assign pred_taken_o  = hit;
  assign pred_target_o = hit_target;

  // Record register
  // Valid stays low until the first edge after reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_q <= '0;
    end else begin
      fetch_q.valid  <= 1'b1;
      fetch_q.pc     <= fetch_pc_i;
      fetch_q.taken  <= hit;
      fetch_q.slot   <= hit_slot;
      fetch_q.target <= hit_target;
    end
  end

  assign fetch_o = fetch_q;

endmodule

// ==== rtl/bp_btb.sv ====
// Branch target buffer holding one target per row and slot, written by execute
`timescale 1ns/1ns

module bp_btb
  import bp_pkg::*;
#(
  // Total entry count, power of two, at least 4
  parameter int unsigned NR_ENTRIES = 8
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Invalidate every entry
  input  logic                                    flush_i,
  // Updates are ignored while debugging
  input  logic                                    debug_mode_i,
  // Fetch PC for the read port
  input  logic [VLEN-1:0]                         vpc_i,
  // Resolved branch from execute
  input  btb_update_t                             btb_update_i,
  // Whole row for the fetch block
  output btb_prediction_t [INSTR_PER_FETCH-1:0]   btb_prediction_o
);

  // One row covers one fetch block
  localparam int unsigned NR_ROWS = NR_ENTRIES / INSTR_PER_FETCH;

  // Row index width
  localparam int unsigned ROW_BITS = $clog2(NR_ROWS);

  // ----------------------------------------
  // Index decode
  // ----------------------------------------

  // No tag, so PCs that differ only above the index alias
  logic [ROW_BITS-1:0]  read_row;
  logic [ROW_BITS-1:0]  update_row;
  logic [SLOT_BITS-1:0] update_slot;
  logic                 update_en;

  // Offset bits are dropped, the row follows right above them
  assign read_row    = vpc_i[FETCH_OFFSET +: ROW_BITS];
  assign update_row  = btb_update_i.pc[FETCH_OFFSET +: ROW_BITS];
  // Slot comes from the halfword bit of the branch PC
  assign update_slot = btb_update_i.pc[FETCH_OFFSET-1 -: SLOT_BITS];

  // Debug mode blocks training
  assign update_en = btb_update_i.valid && !debug_mode_i;

  // ----------------------------------------
  // Entry storage
  // ----------------------------------------

  // Valid bits per row and slot
  logic [INSTR_PER_FETCH-1:0] valid_q [NR_ROWS];

  // Targets per row and slot
  logic [VLEN-1:0] target_q [NR_ROWS][INSTR_PER_FETCH];

  // Valid bits, flush takes priority over a same-cycle update
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < NR_ROWS; r++) begin
        valid_q[r] <= '0;
      end
    end else if (flush_i) begin
      // Drop every entry
      for (int unsigned r = 0; r < NR_ROWS; r++) begin
        valid_q[r] <= '0;
      end
    end else if (update_en) begin
      valid_q[update_row][update_slot] <= 1'b1;
    end
  end

  // Target payload, only meaningful once its valid bit is set
  always_ff @(posedge clk_i) begin
    if (update_en) begin
      target_q[update_row][update_slot] <= btb_update_i.target_address;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // Combinational read, prediction in the same cycle as the PC
  always_comb begin
    for (int unsigned s = 0; s < INSTR_PER_FETCH; s++) begin
      btb_prediction_o[s].valid          = valid_q[read_row][s];
      btb_prediction_o[s].target_address = target_q[read_row][s];
    end
  end

endmodule

// ==== rtl/bp_pc_gen.sv ====
// Fetch PC stage choosing between redirect, predicted target and the next sequential block
`timescale 1ns/1ns

module bp_pc_gen
  import bp_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  // Start address, held stable around reset release
  input  logic [VLEN-1:0] boot_pc_i,
  // Redirect strobe from execute
  input  logic            redirect_i,
  input  logic [VLEN-1:0] redirect_pc_i,
  // Taken decision for the current block
  input  logic            pred_taken_i,
  input  logic [VLEN-1:0] pred_target_i,
  // Current fetch PC
  output logic [VLEN-1:0] fetch_pc_o
);

  // Current and next fetch PC
  logic [VLEN-1:0] pc_q;
  logic [VLEN-1:0] pc_d;

  // Block base of the current PC
  logic [VLEN-1:0] block_base;

  // Start of the following block
  logic [VLEN-1:0] seq_pc;

  // Clear the slot and byte offset so a block entered mid-way
  // still steps to the next aligned block
  assign block_base = {pc_q[VLEN-1:FETCH_OFFSET], {FETCH_OFFSET{1'b0}}};
  assign seq_pc     = block_base + VLEN'(FETCH_BYTES);

  // Next PC priority
  always_comb begin
    // Default is plain sequential fetch
    pc_d = seq_pc;
    if (redirect_i) begin
      // Execute overrides everything
      pc_d = redirect_pc_i;
    end else if (pred_taken_i) begin
      // Follow the buffer hit
      pc_d = pred_target_i;
    end
  end

  // PC register
  // Reset loads the boot address, so the boot block is fetched first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= boot_pc_i;
    end else begin
      // No stall, a new PC every cycle
      pc_q <= pc_d;
    end
  end

  assign fetch_pc_o = pc_q;

endmodule

// ==== rtl/bp_pkg.sv ====
// Branch prediction frontend package with fetch geometry and shared record types
package bp_pkg;

  // ----------------------------------------
  // Fetch geometry
  // ----------------------------------------

  // Width of every PC and branch target
  localparam int unsigned VLEN = 32;

  // Two 16-bit compressed slots per fetch block
  localparam int unsigned INSTR_PER_FETCH = 2;

  // Byte size of one fetch block
  localparam int unsigned FETCH_BYTES = 4;

  // PC bits below the block base, these pick slot and byte
  localparam int unsigned FETCH_OFFSET = $clog2(FETCH_BYTES);

  // Width of a slot index inside a block
  localparam int unsigned SLOT_BITS = $clog2(INSTR_PER_FETCH);

  // ----------------------------------------
  // Record types
  // ----------------------------------------

  // One buffer entry as seen by the read port
  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] target_address;
  } btb_prediction_t;

  // Resolved branch from execute
  // Valid is a single-cycle strobe
  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] pc;
    logic [VLEN-1:0] target_address;
  } btb_update_t;

  // Result for one fetched block, one cycle behind the fetch PC
  typedef struct packed {
    logic                 valid;
    logic [VLEN-1:0]      pc;
    logic                 taken;
    logic [SLOT_BITS-1:0] slot;
    logic [VLEN-1:0]      target;
  } fetch_block_t;

endpackage
